// File: project.f
isa_pkg.sv
pipe_pkg.sv
id_pipe_reg.sv
inst_decoder.sv
regfile.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -f project.f > sim.log 2>&1 &&
    ./obj_dir/Vtb_id_stage >> sim.log 2>&1
grep -q "Testbench passed" sim.log && echo "simulation PASS" || {
    echo "simulation FAIL, see sim.log"
    exit 1
}

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    localparam int n_tests  = 600;
    localparam int n_cycles = 2 + 31 + n_tests + 4;

    // one row per instruction kind
    // word is (random & ~mask) | val
    typedef struct packed {
        logic [31:0] mask;
        logic [31:0] val;
        logic [11:0] alu;
        logic [7:0]  flags;
        logic [1:0]  dst;
        logic [4:0]  code;
    } kind_row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    fs_valid;
    pipe_pkg::fs_to_ds_t     fs_bus;
    logic                    es_allowin;
    pipe_pkg::rf_wr_t        rf_wr;
    pipe_pkg::fwd_sel_t      fwd_sel;
    logic [31:0]             fwd_data;
    pipe_pkg::stall_t        stall;
    logic                    ex_flush;
    logic                    ds_allowin;
    logic                    ds_to_es_valid;
    pipe_pkg::ds_to_es_t     ds_to_es_bus;
    pipe_pkg::br_t           br;
    pipe_pkg::rf_raddr_t     rf_raddr;

    logic [31:0] lfsr_state;
    logic [4:0]  stim_kind;
    logic [31:0] shadow [0:31];
    logic        exp_valid;
    logic [4:0]  exp_kind;
    logic [31:0] exp_word;
    logic [31:0] exp_pc;
    logic        exp_fetch_ex;
    kind_row_t   row;
    logic        exp_allowin;
    logic        exp_out_valid;
    logic        exp_taken;
    logic [31:0] exp_rs;
    logic [31:0] exp_rt;
    logic [31:0] exp_target;
    logic [4:0]  exp_dest;
    logic [4:0]  exp_code;
    logic [7:0]  act_flags;
    logic [31:0] held_pc;
    logic [15:0] held_imm;
    logic        was_held;

    id_stage UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .es_allowin     (es_allowin),
        .rf_wr          (rf_wr),
        .fwd_sel        (fwd_sel),
        .fwd_data       (fwd_data),
        .stall          (stall),
        .ex_flush       (ex_flush),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br             (br),
        .rf_raddr       (rf_raddr)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // mips encodings and expected controls
    // alu bits in order add sub slt sltu and nor or xor sll srl sra lui
    function automatic kind_row_t kind_row(input logic [4:0] kind);
        case (kind)
            5'd0:    return '{32'hfc0007ff, 32'h00000021, 12'h001, 8'h01, 2'd0, 5'd0};
            5'd1:    return '{32'hfc0007ff, 32'h00000023, 12'h002, 8'h01, 2'd0, 5'd0};
            5'd2:    return '{32'hfc0007ff, 32'h0000002a, 12'h004, 8'h01, 2'd0, 5'd0};
            5'd3:    return '{32'hfc0007ff, 32'h0000002b, 12'h008, 8'h01, 2'd0, 5'd0};
            5'd4:    return '{32'hfc0007ff, 32'h00000024, 12'h010, 8'h01, 2'd0, 5'd0};
            5'd5:    return '{32'hfc0007ff, 32'h00000025, 12'h040, 8'h01, 2'd0, 5'd0};
            5'd6:    return '{32'hfc0007ff, 32'h00000026, 12'h080, 8'h01, 2'd0, 5'd0};
            5'd7:    return '{32'hfc0007ff, 32'h00000027, 12'h020, 8'h01, 2'd0, 5'd0};
            5'd8:    return '{32'hffe0003f, 32'h00000000, 12'h100, 8'h81, 2'd0, 5'd0};
            5'd9:    return '{32'hffe0003f, 32'h00000002, 12'h200, 8'h81, 2'd0, 5'd0};
            5'd10:   return '{32'hffe0003f, 32'h00000003, 12'h400, 8'h81, 2'd0, 5'd0};
            5'd11:   return '{32'hfc1fffff, 32'h00000008, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd12:   return '{32'hfc00003f, 32'h0000000c, 12'h000, 8'h00, 2'd0, 5'd8};
            5'd13:   return '{32'hfc00003f, 32'h0000000d, 12'h000, 8'h00, 2'd0, 5'd9};
            5'd14:   return '{32'hfc000000, 32'h24000000, 12'h001, 8'h21, 2'd1, 5'd0};
            5'd15:   return '{32'hfc000000, 32'h30000000, 12'h010, 8'h11, 2'd1, 5'd0};
            5'd16:   return '{32'hfc000000, 32'h34000000, 12'h040, 8'h11, 2'd1, 5'd0};
            5'd17:   return '{32'hfc000000, 32'h38000000, 12'h080, 8'h11, 2'd1, 5'd0};
            5'd18:   return '{32'hffe00000, 32'h3c000000, 12'h800, 8'h21, 2'd1, 5'd0};
            5'd19:   return '{32'hfc000000, 32'h8c000000, 12'h001, 8'h25, 2'd1, 5'd0};
            5'd20:   return '{32'hfc000000, 32'hac000000, 12'h001, 8'h22, 2'd0, 5'd0};
            5'd21:   return '{32'hfc000000, 32'h10000000, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd22:   return '{32'hfc000000, 32'h14000000, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd23:   return '{32'hfc1f0000, 32'h04010000, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd24:   return '{32'hfc1f0000, 32'h04000000, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd25:   return '{32'hfc000000, 32'h08000000, 12'h000, 8'h00, 2'd0, 5'd0};
            5'd26:   return '{32'hfc000000, 32'h0c000000, 12'h001, 8'h49, 2'd2, 5'd0};
            // opcodes 0x30 and up are all unused
            default: return '{32'hc0000000, 32'hc0000000, 12'h000, 8'h00, 2'd0, 5'd10};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic drive_cycle();
        logic [4:0] kind;
        kind_row_t  r;
        kind = 5'(take_bits(5) % 28);
        r = kind_row(kind);
        stim_kind = kind;
        fs_valid = take_bits(2) != 0;
        fs_bus.inst = (take_bits(32) & ~r.mask) | r.val;
        fs_bus.ex = take_bits(3) == 0;
        fs_bus.pc = take_bits(32);
        es_allowin = take_bits(2) != 0;
        case (take_bits(3))
            0:       stall = pipe_pkg::stall_hold;
            1:       stall = pipe_pkg::stall_drain;
            default: stall = pipe_pkg::stall_none;
        endcase
        ex_flush = take_bits(4) == 0;
        rf_wr.we = take_bits(1) != 0;
        rf_wr.addr = 5'(take_bits(5));
        rf_wr.data = take_bits(32);
        fwd_sel.rs_fwd = take_bits(2) == 0;
        fwd_sel.rt_fwd = take_bits(2) == 0;
        fwd_data = take_bits(32);
    endtask

    // reference model of the stage and the register contents
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid    <= 1'b0;
            exp_kind     <= 5'd27;
            exp_word     <= '0;
            exp_pc       <= '0;
            exp_fetch_ex <= 1'b0;
        end else begin
            if (ex_flush) begin
                exp_valid <= 1'b0;
            end else if (exp_allowin) begin
                exp_valid <= fs_valid;
            end
            if (fs_valid && exp_allowin) begin
                exp_kind     <= stim_kind;
                exp_word     <= fs_bus.inst;
                exp_pc       <= fs_bus.pc;
                exp_fetch_ex <= fs_bus.ex;
            end
            if (rf_wr.we && rf_wr.addr != 5'd0) begin
                shadow[rf_wr.addr] <= rf_wr.data;
            end
        end
    end

    always_comb begin
        row = kind_row(exp_kind);
        case (stall)
            pipe_pkg::stall_hold:  exp_allowin = 1'b0;
            pipe_pkg::stall_drain: exp_allowin = 1'b1;
            default:               exp_allowin = !exp_valid || es_allowin;
        endcase
        exp_out_valid = exp_valid && stall == pipe_pkg::stall_none;
        exp_rs = fwd_sel.rs_fwd ? fwd_data :
                 (exp_word[25:21] == 5'd0) ? '0 : shadow[exp_word[25:21]];
        exp_rt = fwd_sel.rt_fwd ? fwd_data :
                 (exp_word[20:16] == 5'd0) ? '0 : shadow[exp_word[20:16]];
        case (row.dst)
            2'd1:    exp_dest = exp_word[20:16];
            2'd2:    exp_dest = 5'd31;
            default: exp_dest = exp_word[15:11];
        endcase
        exp_code = exp_fetch_ex ? 5'd4 : row.code;
        case (exp_kind)
            5'd11, 5'd25, 5'd26: exp_taken = 1'b1;
            5'd21:               exp_taken = exp_rs == exp_rt;
            5'd22:               exp_taken = exp_rs != exp_rt;
            5'd23:               exp_taken = !exp_rs[31];
            5'd24:               exp_taken = exp_rs[31];
            default:             exp_taken = 1'b0;
        endcase
        exp_taken = exp_taken && exp_valid;
        if (exp_kind >= 5'd21 && exp_kind <= 5'd24) begin
            exp_target = exp_pc + 32'd4 + {{14{exp_word[15]}}, exp_word[15:0], 2'b00};
        end else if (exp_kind == 5'd11) begin
            exp_target = exp_rs;
        end else begin
            exp_target = exp_pc + 32'd4;
            exp_target = {exp_target[31:28], exp_word[25:0], 2'b00};
        end
        act_flags = {ds_to_es_bus.src1_is_sa, ds_to_es_bus.src1_is_pc, ds_to_es_bus.src2_is_simm,
                     ds_to_es_bus.src2_is_usimm, ds_to_es_bus.src2_is_8, ds_to_es_bus.load,
                     ds_to_es_bus.store, ds_to_es_bus.gr_we};
    end

    // bus as it stood before each edge
    always_ff @(posedge clk) begin
        held_pc  <= ds_to_es_bus.pc;
        held_imm <= ds_to_es_bus.imm;
        was_held <= !ds_allowin;
    end

    assert property (@(negedge clk) disable iff (!rst_n) ds_allowin == exp_allowin)
        else report_mismatch("ds_allowin", 32'(exp_allowin), 32'(ds_allowin));
    assert property (@(negedge clk) disable iff (!rst_n) ds_to_es_valid == exp_out_valid)
        else report_mismatch("ds_to_es_valid", 32'(exp_out_valid), 32'(ds_to_es_valid));
    assert property (@(negedge clk) disable iff (!rst_n) br.taken == exp_taken)
        else report_mismatch("br.taken", 32'(exp_taken), 32'(br.taken));
    assert property (@(negedge clk) disable iff (!rst_n) !exp_taken || br.target == exp_target)
        else report_mismatch("br.target", exp_target, br.target);
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.alu_op == row.alu)
        else report_mismatch("alu_op", 32'(row.alu), 32'(ds_to_es_bus.alu_op));
    assert property (@(negedge clk) disable iff (!rst_n) !exp_valid || act_flags == row.flags)
        else report_mismatch("src selects/load/store/gr_we", 32'(row.flags), 32'(act_flags));
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.dest == exp_dest)
        else report_mismatch("dest", 32'(exp_dest), 32'(ds_to_es_bus.dest));
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.imm == exp_word[15:0])
        else report_mismatch("imm", 32'(exp_word[15:0]), 32'(ds_to_es_bus.imm));
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.excode == exp_code)
        else report_mismatch("excode", 32'(exp_code), 32'(ds_to_es_bus.excode));
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.ex == (exp_code != 5'd0))
        else report_mismatch("ex", 32'(exp_code != 5'd0), 32'(ds_to_es_bus.ex));
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.rs_value == exp_rs)
        else report_mismatch("rs_value", exp_rs, ds_to_es_bus.rs_value);
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || ds_to_es_bus.rt_value == exp_rt)
        else report_mismatch("rt_value", exp_rt, ds_to_es_bus.rt_value);
    assert property (@(negedge clk) disable iff (!rst_n) !exp_valid || ds_to_es_bus.pc == exp_pc)
        else report_mismatch("ds_to_es_bus.pc", exp_pc, ds_to_es_bus.pc);
    assert property (@(negedge clk) disable iff (!rst_n)
        !exp_valid || rf_raddr == {exp_word[25:21], exp_word[20:16]})
        else report_mismatch("rf_raddr", 32'({exp_word[25:21], exp_word[20:16]}),
                             32'(rf_raddr));
    assert property (@(negedge clk) disable iff (!rst_n) !was_held || ds_to_es_bus.pc == held_pc)
        else report_mismatch("held ds_to_es_bus.pc", held_pc, ds_to_es_bus.pc);
    assert property (@(negedge clk) disable iff (!rst_n) !was_held || ds_to_es_bus.imm == held_imm)
        else report_mismatch("held ds_to_es_bus.imm", 32'(held_imm), 32'(ds_to_es_bus.imm));

    initial begin
        #(n_cycles * 8 + 400);
        $display("watchdog expired before the test sequence finished");
        $display("Testbench failed");
        $fatal(1, "simulation timed out");
    end

    initial begin
        int i;
        lfsr_state = 32'd77;
        rst_n = 1'b0;
        fs_valid = 1'b0;
        fs_bus = '0;
        es_allowin = 1'b1;
        rf_wr = '0;
        fwd_sel = '0;
        fwd_data = '0;
        stall = pipe_pkg::stall_none;
        ex_flush = 1'b0;
        stim_kind = 5'd27;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // give every register a known value first
        for (i = 1; i < 32; i++) begin
            rf_wr.we = 1'b1;
            rf_wr.addr = 5'(i);
            rf_wr.data = take_bits(32);
            @(posedge clk);
            #1;
        end
        repeat (n_tests) begin
            drive_cycle();
            @(posedge clk);
            #1;
        end
        fs_valid = 1'b0;
        stall = pipe_pkg::stall_none;
        es_allowin = 1'b1;
        ex_flush = 1'b0;
        rf_wr.we = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fs_valid,
    input  pipe_pkg::fs_to_ds_t       fs_bus,
    input  logic                      es_allowin,
    input  pipe_pkg::rf_wr_t          rf_wr,
    input  pipe_pkg::fwd_sel_t        fwd_sel,
    input  logic [isa_pkg::xlen-1:0]  fwd_data,
    input  pipe_pkg::stall_t          stall,
    input  logic                      ex_flush,
    output logic                      ds_allowin,
    output logic                      ds_to_es_valid,
    output pipe_pkg::ds_to_es_t       ds_to_es_bus,
    output pipe_pkg::br_t             br,
    output pipe_pkg::rf_raddr_t       rf_raddr
);

    pipe_pkg::fs_to_ds_t      inst_bus;
    logic                     ds_valid;
    logic [isa_pkg::xlen-1:0] rs_value;
    logic [isa_pkg::xlen-1:0] rt_value;

    assign rf_raddr.rs = inst_bus.inst.r.rs;
    assign rf_raddr.rt = inst_bus.inst.r.rt;

    id_pipe_reg u_pipe_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .es_allowin     (es_allowin),
        .stall          (stall),
        .ex_flush       (ex_flush),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .inst_bus       (inst_bus)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr    (rf_raddr),
        .wr       (rf_wr),
        .fwd_sel  (fwd_sel),
        .fwd_data (fwd_data),
        .rs_value (rs_value),
        .rt_value (rt_value)
    );

    inst_decoder u_decoder (
        .inst_bus     (inst_bus),
        .ds_valid     (ds_valid),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .ds_to_es_bus (ds_to_es_bus)
    );

    branch_unit u_branch (
        .inst_bus (inst_bus),
        .ds_valid (ds_valid),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  pipe_pkg::fs_to_ds_t       inst_bus,
    input  logic                      ds_valid,
    input  logic [isa_pkg::xlen-1:0]  rs_value,
    input  logic [isa_pkg::xlen-1:0]  rt_value,
    output pipe_pkg::br_t             br
);

    isa_pkg::inst_t           inst;
    logic [isa_pkg::xlen-1:0] pc_plus4;
    logic [isa_pkg::xlen-1:0] br_offset;
    logic                     is_beq;
    logic                     is_bne;
    logic                     is_bgez;
    logic                     is_bltz;
    logic                     is_jump;
    logic                     is_jr;
    logic                     is_cond;

    assign inst      = inst_bus.inst;
    // targets are relative to the delay slot
    assign pc_plus4  = inst_bus.pc + 32'd4;
    assign br_offset = {{(isa_pkg::xlen-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};

    assign is_beq  = inst.i.op == isa_pkg::op_beq;
    assign is_bne  = inst.i.op == isa_pkg::op_bne;
    assign is_bgez = inst.i.op == isa_pkg::op_regimm && inst.i.rt == isa_pkg::rt_bgez;
    assign is_bltz = inst.i.op == isa_pkg::op_regimm && inst.i.rt == isa_pkg::rt_bltz;
    assign is_jump = inst.j.op == isa_pkg::op_j || inst.j.op == isa_pkg::op_jal;
    assign is_jr   = inst.r.op == isa_pkg::op_special && inst.r.func == isa_pkg::func_jr
                     && inst.r.rt == '0 && inst.r.rd == '0 && inst.r.sa == '0;
    assign is_cond = is_beq | is_bne | is_bgez | is_bltz;

    assign br.taken = ds_valid && ((is_beq && rs_value == rt_value)
                                || (is_bne && rs_value != rt_value)
                                || (is_bgez && !rs_value[isa_pkg::xlen-1])
                                || (is_bltz && rs_value[isa_pkg::xlen-1])
                                || is_jump || is_jr);

    assign br.target = is_cond ? pc_plus4 + br_offset :
                       is_jr   ? rs_value :
                                 {pc_plus4[31:28], inst.j.jidx, 2'b00};

    // at most one branch kind decodes from any word
    always_comb begin
        assert final ($onehot0({is_beq, is_bne, is_bgez, is_bltz, is_jump, is_jr}))
            else $error("branch_unit: word decodes as more than one branch kind");
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pipe_pkg::rf_raddr_t       raddr,
    input  pipe_pkg::rf_wr_t          wr,
    input  pipe_pkg::fwd_sel_t        fwd_sel,
    input  logic [isa_pkg::xlen-1:0]  fwd_data,
    output logic [isa_pkg::xlen-1:0]  rs_value,
    output logic [isa_pkg::xlen-1:0]  rt_value
);

    // r0 is not stored
    logic [isa_pkg::xlen-1:0] regs [1:31];
    logic [isa_pkg::xlen-1:0] rdata_rs;
    logic [isa_pkg::xlen-1:0] rdata_rt;

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // no write-through
    // a same-cycle write needs the forward path
    assign rdata_rs = (raddr.rs == '0) ? '0 : regs[raddr.rs];
    assign rdata_rt = (raddr.rt == '0) ? '0 : regs[raddr.rt];

    assign rs_value = fwd_sel.rs_fwd ? fwd_data : rdata_rs;
    assign rt_value = fwd_sel.rt_fwd ? fwd_data : rdata_rt;

    // a write to r0 is dropped and changes nothing that is read
    property p_r0_write_dropped;
        @(posedge clk) disable iff (!rst_n)
            (wr.we && wr.addr == '0) |=>
                !$stable(raddr) || ($stable(rdata_rs) && $stable(rdata_rt));
    endproperty

    assert property (p_r0_write_dropped)
        else $error("regfile: write to r0 became visible");

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  pipe_pkg::fs_to_ds_t       inst_bus,
    input  logic                      ds_valid,
    input  logic [isa_pkg::xlen-1:0]  rs_value,
    input  logic [isa_pkg::xlen-1:0]  rt_value,
    output pipe_pkg::ds_to_es_t       ds_to_es_bus
);

    isa_pkg::inst_t   inst;
    logic             special;
    logic             sa_zero;
    logic             inst_addu;
    logic             inst_subu;
    logic             inst_slt;
    logic             inst_sltu;
    logic             inst_and;
    logic             inst_or;
    logic             inst_xor;
    logic             inst_nor;
    logic             inst_sll;
    logic             inst_srl;
    logic             inst_sra;
    logic             inst_jr;
    logic             inst_syscall;
    logic             inst_break;
    logic             inst_addiu;
    logic             inst_andi;
    logic             inst_ori;
    logic             inst_xori;
    logic             inst_lui;
    logic             inst_lw;
    logic             inst_sw;
    logic             inst_beq;
    logic             inst_bne;
    logic             inst_bgez;
    logic             inst_bltz;
    logic             inst_j;
    logic             inst_jal;
    logic             inst_known;
    logic             dst_is_r31;
    logic             dst_is_rt;
    logic             writes_gpr;
    isa_pkg::alu_op_t alu_op;

    assign inst    = inst_bus.inst;
    assign special = inst.r.op == isa_pkg::op_special;
    assign sa_zero = inst.r.sa == '0;

    // register forms
    assign inst_addu    = special && sa_zero && inst.r.func == isa_pkg::func_addu;
    assign inst_subu    = special && sa_zero && inst.r.func == isa_pkg::func_subu;
    assign inst_slt     = special && sa_zero && inst.r.func == isa_pkg::func_slt;
    assign inst_sltu    = special && sa_zero && inst.r.func == isa_pkg::func_sltu;
    assign inst_and     = special && sa_zero && inst.r.func == isa_pkg::func_and;
    assign inst_or      = special && sa_zero && inst.r.func == isa_pkg::func_or;
    assign inst_xor     = special && sa_zero && inst.r.func == isa_pkg::func_xor;
    assign inst_nor     = special && sa_zero && inst.r.func == isa_pkg::func_nor;
    assign inst_sll     = special && inst.r.rs == '0 && inst.r.func == isa_pkg::func_sll;
    assign inst_srl     = special && inst.r.rs == '0 && inst.r.func == isa_pkg::func_srl;
    assign inst_sra     = special && inst.r.rs == '0 && inst.r.func == isa_pkg::func_sra;
    assign inst_jr      = special && sa_zero && inst.r.rt == '0 && inst.r.rd == '0
                          && inst.r.func == isa_pkg::func_jr;
    assign inst_syscall = special && inst.r.func == isa_pkg::func_syscall;
    assign inst_break   = special && inst.r.func == isa_pkg::func_break;

    // immediate and jump forms
    assign inst_addiu = inst.i.op == isa_pkg::op_addiu;
    assign inst_andi  = inst.i.op == isa_pkg::op_andi;
    assign inst_ori   = inst.i.op == isa_pkg::op_ori;
    assign inst_xori  = inst.i.op == isa_pkg::op_xori;
    assign inst_lui   = inst.i.op == isa_pkg::op_lui && inst.i.rs == '0;
    assign inst_lw    = inst.i.op == isa_pkg::op_lw;
    assign inst_sw    = inst.i.op == isa_pkg::op_sw;
    assign inst_beq   = inst.i.op == isa_pkg::op_beq;
    assign inst_bne   = inst.i.op == isa_pkg::op_bne;
    assign inst_bgez  = inst.i.op == isa_pkg::op_regimm && inst.i.rt == isa_pkg::rt_bgez;
    assign inst_bltz  = inst.i.op == isa_pkg::op_regimm && inst.i.rt == isa_pkg::rt_bltz;
    assign inst_j     = inst.i.op == isa_pkg::op_j;
    assign inst_jal   = inst.i.op == isa_pkg::op_jal;

    assign writes_gpr = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                      | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_addiu
                      | inst_andi | inst_ori | inst_xori | inst_lui | inst_lw | inst_jal;
    assign inst_known = writes_gpr | inst_sw | inst_beq | inst_bne | inst_bgez | inst_bltz
                      | inst_j | inst_jr | inst_syscall | inst_break;

    assign dst_is_r31 = inst_jal;
    assign dst_is_rt  = inst_addiu | inst_andi | inst_ori | inst_xori | inst_lui | inst_lw;

    always_comb begin
        alu_op = '0;
        // jal computes its link address pc+8 on the adder
        alu_op[isa_pkg::alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        alu_op[isa_pkg::alu_sub]  = inst_subu;
        alu_op[isa_pkg::alu_slt]  = inst_slt;
        alu_op[isa_pkg::alu_sltu] = inst_sltu;
        alu_op[isa_pkg::alu_and]  = inst_and | inst_andi;
        alu_op[isa_pkg::alu_nor]  = inst_nor;
        alu_op[isa_pkg::alu_or]   = inst_or | inst_ori;
        alu_op[isa_pkg::alu_xor]  = inst_xor | inst_xori;
        alu_op[isa_pkg::alu_sll]  = inst_sll;
        alu_op[isa_pkg::alu_srl]  = inst_srl;
        alu_op[isa_pkg::alu_sra]  = inst_sra;
        alu_op[isa_pkg::alu_lui]  = inst_lui;
    end

    always_comb begin
        ds_to_es_bus.ex = 1'b1;
        // fetch error outranks anything found in the word
        if (inst_bus.ex) begin
            ds_to_es_bus.excode = isa_pkg::exc_adel;
        end else if (inst_break) begin
            ds_to_es_bus.excode = isa_pkg::exc_bp;
        end else if (inst_syscall) begin
            ds_to_es_bus.excode = isa_pkg::exc_sys;
        end else if (!inst_known) begin
            ds_to_es_bus.excode = isa_pkg::exc_ri;
        end else begin
            ds_to_es_bus.ex     = 1'b0;
            ds_to_es_bus.excode = '0;
        end
        ds_to_es_bus.alu_op        = alu_op;
        ds_to_es_bus.src1_is_sa    = inst_sll | inst_srl | inst_sra;
        ds_to_es_bus.src1_is_pc    = inst_jal;
        ds_to_es_bus.src2_is_simm  = inst_addiu | inst_lui | inst_lw | inst_sw;
        ds_to_es_bus.src2_is_usimm = inst_andi | inst_ori | inst_xori;
        ds_to_es_bus.src2_is_8     = inst_jal;
        ds_to_es_bus.load          = inst_lw && ds_valid;
        ds_to_es_bus.store         = inst_sw && ds_valid;
        ds_to_es_bus.gr_we         = writes_gpr && ds_valid;
        ds_to_es_bus.dest          = dst_is_r31 ? 5'd31 : dst_is_rt ? inst.i.rt : inst.r.rd;
        ds_to_es_bus.imm           = inst.i.imm;
        ds_to_es_bus.rs_value      = rs_value;
        ds_to_es_bus.rt_value      = rt_value;
        ds_to_es_bus.pc            = inst_bus.pc;
    end

    always_comb begin
        assert final (!ds_valid || $onehot0(ds_to_es_bus.alu_op))
            else $error("inst_decoder: alu_op is not one-hot");
    end

endmodule

// File: id_pipe_reg.sv
`timescale 1ns/1ps

module id_pipe_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fs_valid,
    input  pipe_pkg::fs_to_ds_t fs_bus,
    input  logic               es_allowin,
    input  pipe_pkg::stall_t   stall,
    input  logic               ex_flush,
    output logic               ds_allowin,
    output logic               ds_valid,
    output logic               ds_to_es_valid,
    output pipe_pkg::fs_to_ds_t inst_bus
);

    logic flow_allowin;

    // decode always finishes in one cycle
    assign flow_allowin = !ds_valid || es_allowin;

    always_comb begin
        case (stall)
            pipe_pkg::stall_hold:  ds_allowin = 1'b0;
            pipe_pkg::stall_drain: ds_allowin = 1'b1;
            default:               ds_allowin = flow_allowin;
        endcase
    end

    assign ds_to_es_valid = (stall == pipe_pkg::stall_none) && ds_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ex_flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            inst_bus <= fs_bus;
        end
    end

    // a held instruction stays in the stage
    assert property (@(posedge clk) disable iff (!rst_n)
        (stall == pipe_pkg::stall_hold && ds_valid && !ex_flush) |=> ds_valid)
        else $error("id_pipe_reg: instruction lost during stall_hold");

    // held instruction stays put until the stage lets go
    assert property (@(posedge clk) disable iff (!rst_n)
        (ds_valid && !ds_allowin) |=> $stable(inst_bus))
        else $error("id_pipe_reg: inst_bus changed while held");

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic                        ex;
        isa_pkg::inst_t              inst;
        logic [isa_pkg::xlen-1:0]    pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic                            ex;
        isa_pkg::exc_code_t              excode;
        isa_pkg::alu_op_t                alu_op;
        logic                            src1_is_sa;
        logic                            src1_is_pc;
        logic                            src2_is_simm;
        logic                            src2_is_usimm;
        logic                            src2_is_8;
        logic                            load;
        logic                            store;
        logic                            gr_we;
        logic [isa_pkg::reg_addr_w-1:0]  dest;
        logic [15:0]                     imm;
        logic [isa_pkg::xlen-1:0]        rs_value;
        logic [isa_pkg::xlen-1:0]        rt_value;
        logic [isa_pkg::xlen-1:0]        pc;
    } ds_to_es_t;

    typedef struct packed {
        logic                     taken;
        logic [isa_pkg::xlen-1:0] target;
    } br_t;

    typedef struct packed {
        logic                           we;
        logic [isa_pkg::reg_addr_w-1:0] addr;
        logic [isa_pkg::xlen-1:0]       data;
    } rf_wr_t;

    typedef struct packed {
        logic rs_fwd;
        logic rt_fwd;
    } fwd_sel_t;

    // hold keeps the stage, drain lets the next one in without sending this one on
    typedef enum logic [1:0] {
        stall_none  = 2'b00,
        stall_hold  = 2'b01,
        stall_drain = 2'b10
    } stall_t;

    typedef struct packed {
        logic [isa_pkg::reg_addr_w-1:0] rs;
        logic [isa_pkg::reg_addr_w-1:0] rt;
    } rf_raddr_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef struct packed {
        logic [5:0]            op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            func;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } inst_j_t;

    // one instruction word, three ways to read it
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_t;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function field
    localparam logic [5:0] func_sll     = 6'h00;
    localparam logic [5:0] func_srl     = 6'h02;
    localparam logic [5:0] func_sra     = 6'h03;
    localparam logic [5:0] func_jr      = 6'h08;
    localparam logic [5:0] func_syscall = 6'h0c;
    localparam logic [5:0] func_break   = 6'h0d;
    localparam logic [5:0] func_addu    = 6'h21;
    localparam logic [5:0] func_subu    = 6'h23;
    localparam logic [5:0] func_and     = 6'h24;
    localparam logic [5:0] func_or      = 6'h25;
    localparam logic [5:0] func_xor     = 6'h26;
    localparam logic [5:0] func_nor     = 6'h27;
    localparam logic [5:0] func_slt     = 6'h2a;
    localparam logic [5:0] func_sltu    = 6'h2b;

    // regimm rt field
    localparam logic [reg_addr_w-1:0] rt_bltz = 5'h00;
    localparam logic [reg_addr_w-1:0] rt_bgez = 5'h01;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t exc_adel = 5'd4;
    localparam exc_code_t exc_sys  = 5'd8;
    localparam exc_code_t exc_bp   = 5'd9;
    localparam exc_code_t exc_ri   = 5'd10;

    typedef logic [11:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

endpackage
